//--- design/n64rgb_defines.svh
`ifndef N64RGB_DEFINES_SVH
`define N64RGB_DEFINES_SVH

// width of one colour as it travels on the multiplexed bus
`define N64_COLOR_W 7

// four active-low sync bits sent in the sync cycle
`define N64_SYNC_W 4

// colour width after widening on the output side
`define N64_OUT_COLOR_W 8

// bus cycles per pixel: sync, red, green, blue
`define N64_PHASE_CNT 4

`endif

//--- design/n64_video_pkg.sv
package n64_video_pkg;

`include "n64rgb_defines.svh"

  ////////////////////
  // sync word
  ////////////////////

  // all bits active low, order as on the bus (d[3] down to d[0])
  typedef struct packed {
    logic vsync_n;
    logic clamp_n;
    logic hsync_n;
    logic csync_n;
  } sync_t;

  ////////////////////
  // data bus
  ////////////////////

  // one bus word, read as sync bits in the sync cycle
  // and as a colour in the three colour cycles
  typedef union packed {
    struct packed {
      // upper bus bits carry nothing in the sync cycle
      logic [`N64_COLOR_W-`N64_SYNC_W-1:0] pad;
      sync_t                               sync;
    } sync_view;
    logic [`N64_COLOR_W-1:0] color;
  } dbus_u;

  ////////////////////
  // pixel words
  ////////////////////

  // colour triple at bus width
  typedef struct packed {
    logic [`N64_COLOR_W-1:0] r;
    logic [`N64_COLOR_W-1:0] g;
    logic [`N64_COLOR_W-1:0] b;
  } color_t;

  // content of one demux register
  typedef struct packed {
    sync_t  sync;
    color_t color;
  } vdata_t;

  // consumer output, colours widened
  typedef struct packed {
    sync_t                       sync;
    logic [`N64_OUT_COLOR_W-1:0] r;
    logic [`N64_OUT_COLOR_W-1:0] g;
    logic [`N64_OUT_COLOR_W-1:0] b;
  } pixel_t;

endpackage

//--- design/n64_ctrl_pkg.sv
package n64_ctrl_pkg;

`include "n64rgb_defines.svh"

  ////////////////////
  // bus phase
  ////////////////////

  // position inside the four-cycle pixel
  // PH_BLUE doubles as idle until the next data-sync
  typedef enum logic [$clog2(`N64_PHASE_CNT)-1:0] {
    PH_SYNC  = 2'd0,
    PH_RED   = 2'd1,
    PH_GREEN = 2'd2,
    PH_BLUE  = 2'd3
  } phase_e;

  ////////////////////
  // demux control
  ////////////////////

  // per-cycle control from phase tracker to demux
  typedef struct packed {
    phase_e phase;
    // deblur off when high
    logic   deblur_n;
    // colours of this pixel pass on when high
    logic   blank_n;
  } demux_par_t;

endpackage

//--- design/n64_dsync_phase.sv
`timescale 1ns/1ns

module n64_dsync_phase (
  input  logic                      nclk_i,
  input  logic                      reset_i,
  input  logic                      dsync_n_i,
  input  n64_video_pkg::dbus_u      d_i,
  input  logic                      deblur_n_i,
  output n64_ctrl_pkg::demux_par_t  demux_par_o,
  output logic                      pix_done_o
);

  // cycles since the last data-sync, saturates at blue
  logic [1:0] phase_cnt;
  // hsync_n from the previous sync cycle
  logic       hsync_n_prev;
  // deblur blank pattern
  logic       blank_n;
  logic       sync_cycle;
  logic       hsync_fall;

  assign sync_cycle = ~dsync_n_i;
  // line start: hsync_n goes low between two sync words
  assign hsync_fall = sync_cycle & hsync_n_prev & ~d_i.sync_view.sync.hsync_n;

  ////////////////////
  // phase counter
  ////////////////////

  always_ff @(posedge nclk_i) begin
    if (reset_i) begin
      // idle at blue until the first data-sync
      phase_cnt <= 2'(n64_ctrl_pkg::PH_BLUE);
    end else if (sync_cycle) begin
      // red follows directly after the sync cycle
      phase_cnt <= 2'(n64_ctrl_pkg::PH_RED);
    end else if (phase_cnt != 2'(n64_ctrl_pkg::PH_BLUE)) begin
      phase_cnt <= phase_cnt + 2'd1;
    end
  end

  ////////////////////
  // deblur pattern
  ////////////////////

  always_ff @(posedge nclk_i) begin
    if (reset_i) begin
      hsync_n_prev <= 1'b1;
      blank_n      <= 1'b1;
    end else begin
      if (sync_cycle)
        hsync_n_prev <= d_i.sync_view.sync.hsync_n;
      // deblur off keeps every pixel
      if (deblur_n_i)
        blank_n <= 1'b1;
      else if (hsync_fall)
        blank_n <= 1'b1;
      else if (sync_cycle)
        blank_n <= ~blank_n;
    end
  end

  // pixel in register 1 is complete one cycle after the sync cycle
  always_ff @(posedge nclk_i) begin
    if (reset_i)
      pix_done_o <= 1'b0;
    else
      pix_done_o <= sync_cycle;
  end

  // sync phase comes straight from the strobe, so it lines up with the bus word
  assign demux_par_o.phase    = sync_cycle ? n64_ctrl_pkg::PH_SYNC
                                           : n64_ctrl_pkg::phase_e'(phase_cnt);
  assign demux_par_o.deblur_n = deblur_n_i;
  assign demux_par_o.blank_n  = blank_n;

endmodule

//--- design/n64_vdemux.sv
`timescale 1ns/1ns

`include "n64rgb_defines.svh"

module n64_vdemux (
  input  logic                      nclk_i,
  input  logic                      reset_i,
  input  n64_video_pkg::dbus_u      d_i,
  input  n64_ctrl_pkg::demux_par_t  demux_par_i,
  input  logic                      mode_15bit_n_i,
  output n64_video_pkg::vdata_t     vdata_r0_o,
  output n64_video_pkg::vdata_t     vdata_r1_o
);

  // register 0 collects the pixel in flight
  n64_video_pkg::sync_t  sync_r0;
  n64_video_pkg::color_t color_r0;
  // register 1 holds the last finished pixel
  n64_video_pkg::sync_t  sync_r1;
  n64_video_pkg::color_t color_r1;

  // 15-bit mode as taken at the last frame start
  logic                    n15bit_mode;
  logic                    sync_cycle;
  logic                    pass_color;
  logic                    vsync_fall;
  logic [`N64_COLOR_W-1:0] color_in;

  ////////////////////
  // control unpack
  ////////////////////

  assign sync_cycle = (demux_par_i.phase == n64_ctrl_pkg::PH_SYNC);
  // with deblur on, a blanked pixel leaves the old colours in register 1
  assign pass_color = demux_par_i.deblur_n | demux_par_i.blank_n;
  // frame start: vsync_n drops between two sync words
  assign vsync_fall = sync_r0.vsync_n & ~d_i.sync_view.sync.vsync_n;

  // 15-bit mode drops the two low colour bits
  assign color_in = n15bit_mode ? d_i.color
                                : {d_i.color[`N64_COLOR_W-1:2], 2'b00};

  ////////////////////
  // sync and mode
  ////////////////////

  always_ff @(posedge nclk_i) begin
    if (reset_i) begin
      // inactive sync so the first vsync edge is seen
      sync_r0     <= '1;
      n15bit_mode <= 1'b1;
    end else if (sync_cycle) begin
      if (vsync_fall)
        n15bit_mode <= mode_15bit_n_i;
      sync_r0 <= d_i.sync_view.sync;
    end
  end

  ////////////////////
  // colour demux
  ////////////////////

  always_ff @(posedge nclk_i) begin
    case (demux_par_i.phase)
      n64_ctrl_pkg::PH_RED:   color_r0.r <= color_in;
      n64_ctrl_pkg::PH_GREEN: color_r0.g <= color_in;
      n64_ctrl_pkg::PH_BLUE:  color_r0.b <= color_in;
      default: ;
    endcase
    // shift finished pixel on at each data-sync
    if (sync_cycle) begin
      sync_r1 <= sync_r0;
      if (pass_color)
        color_r1 <= color_r0;
    end
  end

  assign vdata_r0_o = '{sync: sync_r0, color: color_r0};
  assign vdata_r1_o = '{sync: sync_r1, color: color_r1};

endmodule

//--- design/n64_vout.sv
`timescale 1ns/1ns

`include "n64rgb_defines.svh"

module n64_vout (
  input  logic                   nclk_i,
  input  logic                   reset_i,
  input  n64_video_pkg::vdata_t  vdata_i,
  input  logic                   pix_done_i,
  output n64_video_pkg::pixel_t  pixel_o,
  output logic                   pixel_valid_o
);

  // widened colours, still combinational
  logic [`N64_OUT_COLOR_W-1:0] r_wide;
  logic [`N64_OUT_COLOR_W-1:0] g_wide;
  logic [`N64_OUT_COLOR_W-1:0] b_wide;

  ////////////////////
  // widening
  ////////////////////

  // msb repeated into the new lsb, so full scale stays full scale
  assign r_wide = {vdata_i.color.r, vdata_i.color.r[`N64_COLOR_W-1]};
  assign g_wide = {vdata_i.color.g, vdata_i.color.g[`N64_COLOR_W-1]};
  assign b_wide = {vdata_i.color.b, vdata_i.color.b[`N64_COLOR_W-1]};

  ////////////////////
  // output register
  ////////////////////

  // pixel data, taken once per finished pixel
  always_ff @(posedge nclk_i) begin
    if (pix_done_i) begin
      pixel_o.sync <= vdata_i.sync;
      pixel_o.r    <= r_wide;
      pixel_o.g    <= g_wide;
      pixel_o.b    <= b_wide;
    end
  end

  // valid goes with the registered pixel
  // one cycle after pix_done
  always_ff @(posedge nclk_i) begin
    if (reset_i)
      pixel_valid_o <= 1'b0;
    else
      pixel_valid_o <= pix_done_i;
  end

endmodule

//--- design/n64_vpath_top.sv
`timescale 1ns/1ns

`include "n64rgb_defines.svh"

module n64_vpath_top (
  input  logic                    nclk_i,
  input  logic                    reset_i,
  input  logic                    dsync_n_i,
  input  logic [`N64_COLOR_W-1:0] d_i,
  input  logic                    deblur_n_i,
  input  logic                    mode_15bit_n_i,
  output n64_video_pkg::pixel_t   pixel_o,
  output logic                    pixel_valid_o
);

  // bus word with its sync and colour views
  n64_video_pkg::dbus_u      d_bus;
  // phase and deblur control to the demux
  n64_ctrl_pkg::demux_par_t  demux_par;
  // finished pixel strobe
  logic                      pix_done;
  // last finished pixel
  n64_video_pkg::vdata_t     vdata_r1;

  assign d_bus = n64_video_pkg::dbus_u'(d_i);

  ////////////////////
  // stages
  ////////////////////

  n64_dsync_phase u_dsync_phase (
    .nclk_i      (nclk_i),
    .reset_i     (reset_i),
    .dsync_n_i   (dsync_n_i),
    .d_i         (d_bus),
    .deblur_n_i  (deblur_n_i),
    .demux_par_o (demux_par),
    .pix_done_o  (pix_done)
  );

  n64_vdemux u_vdemux (
    .nclk_i         (nclk_i),
    .reset_i        (reset_i),
    .d_i            (d_bus),
    .demux_par_i    (demux_par),
    .mode_15bit_n_i (mode_15bit_n_i),
    .vdata_r0_o     (),
    .vdata_r1_o     (vdata_r1)
  );

  n64_vout u_vout (
    .nclk_i        (nclk_i),
    .reset_i       (reset_i),
    .vdata_i       (vdata_r1),
    .pix_done_i    (pix_done),
    .pixel_o       (pixel_o),
    .pixel_valid_o (pixel_valid_o)
  );

endmodule

//--- sim/n64_vpath_asserts.sv
`timescale 1ns/1ns

module n64_vpath_asserts (
  input logic nclk_i,
  input logic reset_i,
  input logic dsync_n_i,
  input logic pixel_valid_o
);

  // one strobe per pixel, never two in a row
  valid_single_cycle: assert property (
    @(posedge nclk_i) disable iff (reset_i) pixel_valid_o |=> !pixel_valid_o
  ) else $error("pixel_valid_o high in two consecutive cycles");

  // sync cycle leads valid by two cycles
  valid_after_sync: assert property (
    @(posedge nclk_i) disable iff (reset_i) !dsync_n_i |-> ##2 pixel_valid_o
  ) else $error("pixel_valid_o missing two cycles after a sync cycle");

  // and valid never shows up without that sync cycle
  valid_needs_sync: assert property (
    @(posedge nclk_i) disable iff (reset_i) pixel_valid_o |-> $past(!dsync_n_i, 2)
  ) else $error("pixel_valid_o without a sync cycle two cycles before");

  // quiet output while reset is held
  valid_low_in_reset: assert property (
    @(posedge nclk_i) (reset_i && $past(reset_i)) |-> !pixel_valid_o
  ) else $error("pixel_valid_o high during reset");

endmodule

bind n64_vpath_top n64_vpath_asserts u_asserts (
  .nclk_i        (nclk_i),
  .reset_i       (reset_i),
  .dsync_n_i     (dsync_n_i),
  .pixel_valid_o (pixel_valid_o)
);

//--- sim/tb_n64_vpath.sv
`timescale 1ns/1ns

`include "n64rgb_defines.svh"

module tb_n64_vpath;

  localparam int NUM_LINES   = 39;
  localparam int RESET_CYCLE = 8;

  logic                    nclk_i;
  logic                    reset_i;
  logic                    dsync_n_i;
  logic [`N64_COLOR_W-1:0] d_i;
  logic                    deblur_n_i;
  logic                    mode_15bit_n_i;
  n64_video_pkg::pixel_t   pixel_o;
  logic                    pixel_valid_o;

  // one word per bus cycle, fields as in the data file
  logic [51:0] lines [0:NUM_LINES-1];

  n64_vpath_top dut (
    .nclk_i         (nclk_i),
    .reset_i        (reset_i),
    .dsync_n_i      (dsync_n_i),
    .d_i            (d_i),
    .deblur_n_i     (deblur_n_i),
    .mode_15bit_n_i (mode_15bit_n_i),
    .pixel_o        (pixel_o),
    .pixel_valid_o  (pixel_valid_o)
  );

  // 10 ns period
  always #5 nclk_i = ~nclk_i;

  ////////////////////
  // helpers
  ////////////////////

  // section of the data file a line belongs to
  function automatic string test_name(input int idx);
    if (idx < 4)
      return "first_pixel";
    else if (idx < 12)
      return "full_mode";
    else if (idx < 20)
      return "mode_15bit";
    else if (idx < 24)
      return "mode_restore";
    else
      return "deblur";
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  // drive one line on the falling edge
  task automatic drive_line(input int idx);
    logic [51:0] w;
    w              = lines[idx];
    dsync_n_i      = w[48];
    d_i            = w[46:40];
    deblur_n_i     = w[36];
    mode_15bit_n_i = w[32];
  endtask

  // outputs after the rising edge that took line idx
  task automatic check_line(input int idx);
    logic [3:0]  chk;
    logic [27:0] exp_pix;
    chk     = lines[idx][31:28];
    exp_pix = lines[idx][27:0];
    if (chk == 4'd0) begin
      assert (pixel_valid_o == 1'b0)
      else stop_on_error($sformatf("unexpected valid strobe after line %0d in %s",
                                   idx, test_name(idx)));
    end else begin
      assert (pixel_valid_o == 1'b1)
      else stop_on_error($sformatf("valid strobe missing after line %0d in %s",
                                   idx, test_name(idx)));
      // flag 2 checks the strobe only
      if (chk == 4'd1) begin
        assert (pixel_o == exp_pix)
        else stop_on_error($sformatf("** Error %s line %0d: expected %h, actual %h",
                                     test_name(idx), idx, exp_pix, pixel_o));
      end
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    nclk_i         = 1'b0;
    reset_i        = 1'b1;
    dsync_n_i      = 1'b1;
    d_i            = '0;
    deblur_n_i     = 1'b1;
    mode_15bit_n_i = 1'b1;
    $readmemh("sim/n64_vpath_testdata.txt", lines);

    // valid must stay low through reset
    repeat (RESET_CYCLE) begin
      @(negedge nclk_i);
      assert (pixel_valid_o == 1'b0)
      else stop_on_error("pixel_valid_o went high during reset");
    end
    reset_i = 1'b0;

    for (int i = 0; i < NUM_LINES; i++) begin
      if (i > 0)
        check_line(i - 1);
      drive_line(i);
      @(negedge nclk_i);
    end
    check_line(NUM_LINES - 1);

    $display("Result: PASSED");
    $finish;
  end

  ////////////////////
  // watchdog
  ////////////////////

  initial begin
    #(RESET_CYCLE * 10 + NUM_LINES * 10 + 200);
    $display("watchdog expired before the test data was done");
    $display("Result: FAILED");
    $fatal(1);
  end

endmodule

//--- vlog.f
+incdir+design
design/n64_video_pkg.sv
design/n64_ctrl_pkg.sv
design/n64_dsync_phase.sv
design/n64_vdemux.sv
design/n64_vout.sv
design/n64_vpath_top.sv
sim/n64_vpath_asserts.sv
sim/tb_n64_vpath.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_n64_vpath
FLIST     := vlog.f
OBJDIR    := obj_dir

BIN     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST)) design/n64rgb_defines.svh
DATA    := sim/n64_vpath_testdata.txt

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: $(BIN) $(DATA)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(OBJDIR)

//--- sim/n64_vpath_testdata.txt
// dsync_n _ d _ deblur_n _ mode_15bit_n _ chk _ expected {sync,r8,g8,b8}
// chk 0 no valid, 1 valid and pixel, 2 valid only; results after that line's edge
0_06_1_1_0_0000000
1_5B_1_1_2_0000000
1_27_1_1_0_0000000
1_71_1_1_0_0000000
0_0F_1_0_0_0000000
1_13_1_0_1_6B74EE3
1_6E_1_0_0_0000000
1_3D_1_0_0_0000000
0_06_1_0_0_0000000
1_5B_1_0_1_F26DD7A
1_27_1_0_0_0000000
1_71_1_0_0_0000000
0_0F_1_1_0_0000000
1_13_1_1_1_6B148E1
1_6E_1_1_0_0000000
1_3D_1_1_0_0000000
0_06_1_1_0_0000000
1_7F_1_1_1_F20D978
1_00_1_1_0_0000000
1_40_1_1_0_0000000
0_0C_0_1_0_0000000
1_01_0_1_1_6FF0081
1_02_0_1_0_0000000
1_03_0_1_0_0000000
0_0F_0_1_0_0000000
1_11_0_1_1_C020406
1_22_0_1_0_0000000
1_33_0_1_0_0000000
0_0F_0_1_0_0000000
1_44_0_1_1_F020406
1_55_0_1_0_0000000
1_66_0_1_0_0000000
0_0B_0_1_0_0000000
1_7E_0_1_1_F89ABCD
1_7E_0_1_0_0000000
1_7E_0_1_0_0000000
0_0F_0_1_0_0000000
1_00_0_1_1_B89ABCD
1_00_0_1_0_0000000
